// File: Bender.yml
package:
  name: dhcp_client

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/dhcp_types_pkg.sv
      - source/dhcp_fsm_pkg.sv
      - source/dhcp_rx_parser.sv
      - source/dhcp_client_core.sv
      - source/dhcp_tx_builder.sv
      - source/dhcp_client.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_dhcp_client.sv

// File: filelist.f
+incdir+include
source/dhcp_types_pkg.sv
source/dhcp_fsm_pkg.sv
source/dhcp_rx_parser.sv
source/dhcp_client_core.sv
source/dhcp_tx_builder.sv
source/dhcp_client.sv
test/tb_dhcp_client.sv

// File: include/dhcp_consts.svh
`ifndef DHCP_CONSTS_SVH
`define DHCP_CONSTS_SVH

// UDP ports
`define DHCP_SRV_PORT 16'd67
`define DHCP_CLI_PORT 16'd68

// BOOTP op and hardware type
`define DHCP_OP_REQUEST 8'd1
`define DHCP_OP_REPLY   8'd2
`define DHCP_HTYPE_ETH  8'd1
`define DHCP_HLEN_ETH   8'd6

// Option codes
`define DHCP_OPT_PAD         8'd0
`define DHCP_OPT_SUBNET_MASK 8'd1
`define DHCP_OPT_REQ_IP      8'd50
`define DHCP_OPT_LEASE_TIME  8'd51
`define DHCP_OPT_MSG_TYPE    8'd53
`define DHCP_OPT_SERVER_ID   8'd54
`define DHCP_OPT_END         8'd255

// Message types
`define DHCP_MSG_DISCOVER 8'd1
`define DHCP_MSG_OFFER    8'd2
`define DHCP_MSG_REQUEST  8'd3
`define DHCP_MSG_ACK      8'd5
`define DHCP_MSG_NAK      8'd6

// Byte offsets in the BOOTP header
`define DHCP_OFS_XID        16'd4
`define DHCP_OFS_FLAGS      16'd10
`define DHCP_OFS_YIADDR     16'd16
`define DHCP_OFS_CHADDR     16'd28
`define DHCP_OFS_COOKIE     16'd236
`define DHCP_OPTIONS_OFFSET 16'd240
`define DHCP_MAGIC_COOKIE   32'h63825363

`define DHCP_TX_LEN          16'd300
`define DHCP_TIMEOUT_DEFAULT 1000000 // Cycles per reply
`define DHCP_RETRIES_DEFAULT 3

`endif

// File: source/dhcp_client.sv
`timescale 1ns/1ps
`default_nettype none
`include "dhcp_consts.svh"

module dhcp_client #(
  parameter dhcp_types_pkg::mac_addr_t MAC_ADDR = 48'h02_00_00_00_00_01,
  parameter int TIMEOUT_CYCLES = `DHCP_TIMEOUT_DEFAULT,
  parameter int RETRIES        = `DHCP_RETRIES_DEFAULT
) (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  dhcp_types_pkg::byte_t rx_d,
  input  logic                  rx_v,
  input  logic                  rx_sof,
  input  logic                  rx_eof,
  input  logic                  rx_err,
  input  dhcp_types_pkg::port_t rx_src_port,
  input  dhcp_types_pkg::len_t  rx_length,
  output dhcp_types_pkg::byte_t tx_d,
  output logic                  tx_v,
  output logic                  tx_sof,
  output logic                  tx_eof,
  input  logic                  ipv4_req,
  output dhcp_types_pkg::ipv4_t ipv4_addr,
  output dhcp_types_pkg::ipv4_t ipv4_mask,
  output logic                  ipv4_val,
  output logic                  ok,
  output logic                  timeout
);
  import dhcp_types_pkg::*;

  // Parser to core
  logic      msg_val;
  byte_t     msg_op;
  xid_t      msg_xid;
  msg_type_t msg_type;
  ipv4_t     msg_yiaddr, msg_server_id, msg_mask;
  lease_t    msg_lease;

  // Core to builder
  logic      tx_start, tx_busy;
  msg_type_t tx_type;
  xid_t      tx_xid;
  ipv4_t     tx_req_ip, tx_server_id;

  dhcp_rx_parser u_rx_parser (
    .clk           (clk),
    .fsm_rst       (fsm_rst),
    .rx_d          (rx_d),
    .rx_v          (rx_v),
    .rx_sof        (rx_sof),
    .rx_eof        (rx_eof),
    .rx_err        (rx_err),
    .rx_src_port   (rx_src_port),
    .rx_length     (rx_length),
    .msg_val       (msg_val),
    .msg_op        (msg_op),
    .msg_xid       (msg_xid),
    .msg_type      (msg_type),
    .msg_yiaddr    (msg_yiaddr),
    .msg_server_id (msg_server_id),
    .msg_mask      (msg_mask),
    .msg_lease     (msg_lease)
  );

  dhcp_client_core #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
    .RETRIES        (RETRIES)
  ) u_client_core (
    .clk           (clk),
    .fsm_rst       (fsm_rst),
    .ipv4_req      (ipv4_req),
    .msg_val       (msg_val),
    .msg_op        (msg_op),
    .msg_xid       (msg_xid),
    .msg_type      (msg_type),
    .msg_yiaddr    (msg_yiaddr),
    .msg_server_id (msg_server_id),
    .msg_mask      (msg_mask),
    .msg_lease     (msg_lease),
    .tx_busy       (tx_busy),
    .tx_start      (tx_start),
    .tx_type       (tx_type),
    .tx_xid        (tx_xid),
    .tx_req_ip     (tx_req_ip),
    .tx_server_id  (tx_server_id),
    .ipv4_addr     (ipv4_addr),
    .ipv4_mask     (ipv4_mask),
    .ipv4_val      (ipv4_val),
    .ok            (ok),
    .timeout       (timeout)
  );

  dhcp_tx_builder #(
    .MAC_ADDR (MAC_ADDR)
  ) u_tx_builder (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .tx_start     (tx_start),
    .tx_type      (tx_type),
    .tx_xid       (tx_xid),
    .tx_req_ip    (tx_req_ip),
    .tx_server_id (tx_server_id),
    .tx_d         (tx_d),
    .tx_v         (tx_v),
    .tx_sof       (tx_sof),
    .tx_eof       (tx_eof),
    .tx_busy      (tx_busy)
  );

endmodule

`default_nettype wire

// File: source/dhcp_client_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "dhcp_consts.svh"

module dhcp_client_core #(
  parameter int TIMEOUT_CYCLES = `DHCP_TIMEOUT_DEFAULT,
  parameter int RETRIES        = `DHCP_RETRIES_DEFAULT
) (
  input  logic                      clk,
  input  logic                      fsm_rst,
  input  logic                      ipv4_req,
  input  logic                      msg_val,
  input  dhcp_types_pkg::byte_t     msg_op,
  input  dhcp_types_pkg::xid_t      msg_xid,
  input  dhcp_types_pkg::msg_type_t msg_type,
  input  dhcp_types_pkg::ipv4_t     msg_yiaddr,
  input  dhcp_types_pkg::ipv4_t     msg_server_id,
  input  dhcp_types_pkg::ipv4_t     msg_mask,
  input  dhcp_types_pkg::lease_t    msg_lease,
  input  logic                      tx_busy,
  output logic                      tx_start,
  output dhcp_types_pkg::msg_type_t tx_type,
  output dhcp_types_pkg::xid_t      tx_xid,
  output dhcp_types_pkg::ipv4_t     tx_req_ip,
  output dhcp_types_pkg::ipv4_t     tx_server_id,
  output dhcp_types_pkg::ipv4_t     ipv4_addr,
  output dhcp_types_pkg::ipv4_t     ipv4_mask,
  output logic                      ipv4_val,
  output logic                      ok,
  output logic                      timeout
);
  import dhcp_types_pkg::*;
  import dhcp_fsm_pkg::*;

  localparam int WW = $clog2(TIMEOUT_CYCLES + 1);
  localparam int RW = $clog2(RETRIES + 2);
  localparam logic [WW-1:0] WAIT_MAX  = WW'(TIMEOUT_CYCLES - 1);
  localparam logic [RW-1:0] RETRY_MAX = RW'(RETRIES);

  client_state_t state;
  xid_t          xid_ctr;
  logic [WW-1:0] wait_cnt;
  logic [RW-1:0] retry_cnt;
  logic          reply_ok, offer_hit, ack_hit, nak_hit, wait_done, restart;
  logic          disc_go, req_go;

  // Only replies to our own transaction count
  assign reply_ok  = msg_val && (msg_op == `DHCP_OP_REPLY) && (msg_xid == tx_xid);
  assign offer_hit = reply_ok && state == wait_offer && msg_type == `DHCP_MSG_OFFER;
  assign ack_hit   = reply_ok && state == wait_ack && msg_type == `DHCP_MSG_ACK &&
                     msg_lease != '0; // ACK always carries a lease
  assign nak_hit   = reply_ok && state == wait_ack && msg_type == `DHCP_MSG_NAK;
  assign wait_done = !tx_busy && wait_cnt == WAIT_MAX &&
                     (state == wait_offer || state == wait_ack);
  assign restart   = nak_hit || (wait_done && !offer_hit && !ack_hit);

  assign disc_go = !tx_busy && (state == send_discover ||
                   (ipv4_req && (state == idle || state == failed || state == bound)));
  assign req_go  = !tx_busy && (state == send_request || offer_hit);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state     <= idle;
      xid_ctr   <= '0;
      wait_cnt  <= '0;
      retry_cnt <= '0;
      tx_start  <= 1'b0;
      ipv4_val  <= 1'b0;
      ok        <= 1'b0;
      timeout   <= 1'b0;
    end else begin
      xid_ctr  <= xid_ctr + 32'd1;
      tx_start <= 1'b0;
      ok       <= 1'b0;
      timeout  <= 1'b0;
      wait_cnt <= tx_busy ? '0 : wait_cnt + 1'b1; // Runs once the packet is out
      case (state)
        idle, failed, bound: begin
          if (ipv4_req) begin
            ipv4_val  <= 1'b0;
            retry_cnt <= '0;
            state     <= send_discover;
          end
        end
        wait_offer: if (offer_hit) state <= send_request;
        wait_ack: begin
          if (ack_hit) begin
            ipv4_val <= 1'b1;
            ok       <= 1'b1;
            state    <= bound;
          end
        end
        default: ;
      endcase
      if (restart) begin
        if (retry_cnt == RETRY_MAX) begin
          timeout <= 1'b1;
          state   <= failed;
        end else begin
          retry_cnt <= retry_cnt + 1'b1;
          state     <= send_discover;
        end
      end
      if (disc_go || req_go) begin
        tx_start <= 1'b1;
        wait_cnt <= '0;
        state    <= disc_go ? wait_offer : wait_ack;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (disc_go) begin
      tx_type <= `DHCP_MSG_DISCOVER;
      tx_xid  <= xid_ctr; // Fresh xid per attempt
    end
    if (req_go) tx_type <= `DHCP_MSG_REQUEST;
    if (offer_hit) begin
      tx_req_ip    <= msg_yiaddr;
      tx_server_id <= msg_server_id;
    end
    if (ack_hit) begin
      ipv4_addr <= msg_yiaddr;
      ipv4_mask <= msg_mask;
    end
  end

endmodule

`default_nettype wire

// File: source/dhcp_fsm_pkg.sv
`default_nettype none

package dhcp_fsm_pkg;

  // Receive option walker
  typedef enum logic [2:0] {
    header,
    opt_kind,
    opt_len,
    opt_data,
    skip
  } rx_state_t;

  // Client transaction
  typedef enum logic [2:0] {
    idle,
    send_discover,
    wait_offer,
    send_request,
    wait_ack,
    bound,
    failed
  } client_state_t;

endpackage

`default_nettype wire

// File: source/dhcp_rx_parser.sv
`timescale 1ns/1ps
`default_nettype none
`include "dhcp_consts.svh"

module dhcp_rx_parser (
  input  logic                     clk,
  input  logic                     fsm_rst,
  input  dhcp_types_pkg::byte_t    rx_d,
  input  logic                     rx_v,
  input  logic                     rx_sof,
  input  logic                     rx_eof,
  input  logic                     rx_err,
  input  dhcp_types_pkg::port_t    rx_src_port,
  input  dhcp_types_pkg::len_t     rx_length,
  output logic                     msg_val,
  output dhcp_types_pkg::byte_t    msg_op,
  output dhcp_types_pkg::xid_t     msg_xid,
  output dhcp_types_pkg::msg_type_t msg_type,
  output dhcp_types_pkg::ipv4_t    msg_yiaddr,
  output dhcp_types_pkg::ipv4_t    msg_server_id,
  output dhcp_types_pkg::ipv4_t    msg_mask,
  output dhcp_types_pkg::lease_t   msg_lease
);
  import dhcp_types_pkg::*;
  import dhcp_fsm_pkg::*;

  rx_state_t state, cur_state;
  len_t      byte_cnt, ofs, exp_len, len_now;
  byte_t     kind, opt_length, opt_cnt;
  logic      receiving, port_ok, err_seen, end_seen;
  logic      active, port_now, err_now, end_now, pkt_good;

  // First byte restarts everything
  assign active    = rx_v && (rx_sof || receiving);
  assign ofs       = rx_sof ? '0 : byte_cnt;
  assign cur_state = rx_sof ? header : state;

  assign port_now = rx_sof ? (rx_src_port == `DHCP_SRV_PORT) : port_ok;
  assign err_now  = (!rx_sof && err_seen) || rx_err;
  assign len_now  = rx_sof ? rx_length : exp_len;
  assign end_now  = (!rx_sof && end_seen) ||
                    (cur_state == opt_kind && rx_d == `DHCP_OPT_END);
  assign pkt_good = port_now && !err_now && end_now && (ofs + 16'd1 == len_now);

  ////////////////////////////////////////
  // Packet control
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state     <= header;
      byte_cnt  <= '0;
      receiving <= 1'b0;
      port_ok   <= 1'b0;
      err_seen  <= 1'b0;
      end_seen  <= 1'b0;
      msg_val   <= 1'b0;
    end else begin
      msg_val <= 1'b0;
      if (active) begin
        byte_cnt  <= ofs + 16'd1;
        receiving <= !rx_eof;
        port_ok   <= port_now;
        err_seen  <= err_now;
        end_seen  <= end_now;
        msg_val   <= rx_eof && pkt_good;
        case (cur_state)
          header: state <= (ofs == `DHCP_OPTIONS_OFFSET - 16'd1) ? opt_kind : header;
          opt_kind: begin
            if (rx_d == `DHCP_OPT_END) state <= skip;
            else if (rx_d != `DHCP_OPT_PAD) state <= opt_len; // PAD is one byte
            else state <= opt_kind;
          end
          opt_len:  state <= (rx_d == 8'd0) ? opt_kind : opt_data;
          opt_data: state <= (opt_cnt == opt_length - 8'd1) ? opt_kind : opt_data;
          default:  state <= skip; // Trailing pad after END
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // Field capture
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (active) begin
      if (rx_sof) begin
        exp_len       <= rx_length;
        msg_type      <= '0;
        msg_server_id <= '0;
        msg_mask      <= '0;
        msg_lease     <= '0;
      end
      if (ofs == 16'd0) msg_op <= rx_d;
      if (ofs >= `DHCP_OFS_XID && ofs < `DHCP_OFS_XID + 16'd4)
        msg_xid <= {msg_xid[23:0], rx_d};
      if (ofs >= `DHCP_OFS_YIADDR && ofs < `DHCP_OFS_YIADDR + 16'd4)
        msg_yiaddr <= {msg_yiaddr[23:0], rx_d};
      case (cur_state)
        opt_kind: kind <= rx_d;
        opt_len: begin
          opt_length <= rx_d;
          opt_cnt    <= 8'd0;
        end
        opt_data: begin
          opt_cnt <= opt_cnt + 8'd1;
          case (kind)
            `DHCP_OPT_MSG_TYPE:    msg_type      <= rx_d;
            `DHCP_OPT_SERVER_ID:   msg_server_id <= {msg_server_id[23:0], rx_d};
            `DHCP_OPT_SUBNET_MASK: msg_mask      <= {msg_mask[23:0], rx_d};
            `DHCP_OPT_LEASE_TIME:  msg_lease     <= {msg_lease[23:0], rx_d};
            default: ; // Unknown option, just walked over
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/dhcp_tx_builder.sv
`timescale 1ns/1ps
`default_nettype none
`include "dhcp_consts.svh"

module dhcp_tx_builder #(
  parameter dhcp_types_pkg::mac_addr_t MAC_ADDR = 48'h02_00_00_00_00_01
) (
  input  logic                      clk,
  input  logic                      fsm_rst,
  input  logic                      tx_start,
  input  dhcp_types_pkg::msg_type_t tx_type,
  input  dhcp_types_pkg::xid_t      tx_xid,
  input  dhcp_types_pkg::ipv4_t     tx_req_ip,
  input  dhcp_types_pkg::ipv4_t     tx_server_id,
  output dhcp_types_pkg::byte_t     tx_d,
  output logic                      tx_v,
  output logic                      tx_sof,
  output logic                      tx_eof,
  output logic                      tx_busy
);
  import dhcp_types_pkg::*;

  msg_type_t lat_type;
  xid_t      lat_xid;
  ipv4_t     lat_req_ip, lat_server_id;
  len_t      byte_cnt, sel_cnt, rel, mac_k;
  byte_t     sel_byte;
  logic      is_req;

  // Big-endian byte k of a 32-bit word
  function automatic byte_t word_byte(input logic [31:0] w, input len_t k);
    return w[8*(3 - k[1:0]) +: 8];
  endfunction

  assign sel_cnt = tx_v ? byte_cnt : '0;
  assign rel     = sel_cnt - `DHCP_OPTIONS_OFFSET;
  assign mac_k   = sel_cnt - `DHCP_OFS_CHADDR;
  assign is_req  = (lat_type == `DHCP_MSG_REQUEST);
  assign tx_busy = tx_v;

  ////////////////////////////////////////
  // Byte select
  ////////////////////////////////////////

  always_comb begin
    sel_byte = 8'h00;
    if (sel_cnt >= `DHCP_OPTIONS_OFFSET) begin
      case (rel)
        16'd0:  sel_byte = `DHCP_OPT_MSG_TYPE;
        16'd1:  sel_byte = 8'd1;
        16'd2:  sel_byte = lat_type;
        16'd3:  sel_byte = is_req ? `DHCP_OPT_REQ_IP : `DHCP_OPT_END;
        16'd4, 16'd10: sel_byte = is_req ? 8'd4 : 8'd0;
        16'd5, 16'd6, 16'd7, 16'd8:
          sel_byte = is_req ? word_byte(lat_req_ip, rel - 16'd5) : 8'd0;
        16'd9:  sel_byte = is_req ? `DHCP_OPT_SERVER_ID : 8'd0;
        16'd11, 16'd12, 16'd13, 16'd14:
          sel_byte = is_req ? word_byte(lat_server_id, rel - 16'd11) : 8'd0;
        16'd15: sel_byte = is_req ? `DHCP_OPT_END : 8'd0;
        default: sel_byte = 8'h00; // Zero padding
      endcase
    end else if (sel_cnt >= `DHCP_OFS_COOKIE) begin
      sel_byte = word_byte(`DHCP_MAGIC_COOKIE, sel_cnt - `DHCP_OFS_COOKIE);
    end else if (sel_cnt >= `DHCP_OFS_CHADDR && sel_cnt < `DHCP_OFS_CHADDR + 16'd6) begin
      sel_byte = MAC_ADDR[8*(5 - mac_k[2:0]) +: 8];
    end else if (sel_cnt == `DHCP_OFS_FLAGS) begin
      sel_byte = 8'h80; // Broadcast reply
    end else if (sel_cnt >= `DHCP_OFS_XID && sel_cnt < `DHCP_OFS_XID + 16'd4) begin
      sel_byte = word_byte(lat_xid, sel_cnt - `DHCP_OFS_XID);
    end else if (sel_cnt == 16'd2) begin
      sel_byte = `DHCP_HLEN_ETH;
    end else if (sel_cnt == 16'd1) begin
      sel_byte = `DHCP_HTYPE_ETH;
    end else if (sel_cnt == 16'd0) begin
      sel_byte = `DHCP_OP_REQUEST;
    end
  end

  ////////////////////////////////////////
  // Stream control
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      tx_v     <= 1'b0;
      tx_sof   <= 1'b0;
      tx_eof   <= 1'b0;
      byte_cnt <= '0;
    end else begin
      tx_sof <= 1'b0;
      if (!tx_v) begin
        if (tx_start) begin
          tx_v     <= 1'b1;
          tx_sof   <= 1'b1;
          byte_cnt <= 16'd1;
        end
      end else if (tx_eof) begin
        tx_v   <= 1'b0;
        tx_eof <= 1'b0;
      end else begin
        tx_eof   <= (byte_cnt == `DHCP_TX_LEN - 16'd1);
        byte_cnt <= byte_cnt + 16'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    tx_d <= sel_byte;
    if (!tx_v && tx_start) begin
      lat_type      <= tx_type;
      lat_xid       <= tx_xid;
      lat_req_ip    <= tx_req_ip;
      lat_server_id <= tx_server_id;
    end
  end

endmodule

`default_nettype wire

// File: source/dhcp_types_pkg.sv
`default_nettype none

package dhcp_types_pkg;

  // Addresses
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_t;

  // UDP side
  typedef logic [15:0] port_t;
  typedef logic [15:0] len_t;
  typedef logic [7:0]  byte_t;

  // DHCP fields
  typedef logic [31:0] xid_t;
  typedef logic [7:0]  msg_type_t;
  typedef logic [31:0] lease_t; // Seconds

endpackage

`default_nettype wire

// File: test/tb_dhcp_client.sv
`timescale 1ns/1ps
`default_nettype none
`include "dhcp_consts.svh"

module tb_dhcp_client;
  import dhcp_types_pkg::*;

  localparam int        CLK_PERIOD     = 8;
  localparam int        TIMEOUT_CYCLES = 1000;
  localparam int        RETRIES        = 2;
  localparam mac_addr_t MAC            = 48'h02_1a_2b_3c_4d_5e;
  localparam ipv4_t     SERVER_ID      = 32'h0a_00_00_01;
  localparam lease_t    LEASE          = 32'd3600;

  localparam int NUM_ROWS   = 5;
  localparam int REPLY_LEN  = 272;
  localparam int PKT_MAX    = 512;
  localparam int WAIT_LIMIT = TIMEOUT_CYCLES + 2 * `DHCP_TX_LEN + 100;
  localparam int WATCHDOG_CYCLES =
    NUM_ROWS * (RETRIES + 1) * (TIMEOUT_CYCLES + 2 * `DHCP_TX_LEN);

  // Server behaviors
  localparam int SRV_GOOD      = 0;
  localparam int SRV_WRONG_XID = 1;
  localparam int SRV_NAK       = 2;
  localparam int SRV_SILENT    = 3;
  localparam int SRV_BAD_LEN   = 4;

  logic  clk, fsm_rst;
  byte_t rx_d;
  logic  rx_v, rx_sof, rx_eof, rx_err;
  port_t rx_src_port;
  len_t  rx_length;
  byte_t tx_d;
  logic  tx_v, tx_sof, tx_eof;
  logic  ipv4_req;
  ipv4_t ipv4_addr, ipv4_mask;
  logic  ipv4_val, ok, timeout;

  // Scenario table
  string row_name     [0:NUM_ROWS-1];
  int    row_beh      [0:NUM_ROWS-1];
  bit    row_exp_ok   [0:NUM_ROWS-1];
  int    row_exp_disc [0:NUM_ROWS-1];

  byte_t cap_buf [0:PKT_MAX-1];
  byte_t pkt     [0:PKT_MAX-1];
  byte_t reply   [0:REPLY_LEN-1];
  int    cap_len, pkt_len, pkt_cnt, ok_cnt, to_cnt, val_cnt;

  int          err_cnt, pass_cnt, discs, reqs;
  logic        bad_offer;
  xid_t        disc_xid;
  ipv4_t       offer_ip, offer_mask;
  logic [31:0] rng;

  dhcp_client #(
    .MAC_ADDR       (MAC),
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
    .RETRIES        (RETRIES)
  ) u_dut (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .rx_d        (rx_d),
    .rx_v        (rx_v),
    .rx_sof      (rx_sof),
    .rx_eof      (rx_eof),
    .rx_err      (rx_err),
    .rx_src_port (rx_src_port),
    .rx_length   (rx_length),
    .tx_d        (tx_d),
    .tx_v        (tx_v),
    .tx_sof      (tx_sof),
    .tx_eof      (tx_eof),
    .ipv4_req    (ipv4_req),
    .ipv4_addr   (ipv4_addr),
    .ipv4_mask   (ipv4_mask),
    .ipv4_val    (ipv4_val),
    .ok          (ok),
    .timeout     (timeout)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // Transmit capture and pulse counters
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (fsm_rst) begin
      cap_len = 0;
      pkt_cnt = 0;
      ok_cnt  = 0;
      to_cnt  = 0;
      val_cnt = 0;
    end else begin
      if (ok) ok_cnt++;
      if (timeout) to_cnt++;
      if (ipv4_val) val_cnt++;
      if (tx_v) begin
        if (tx_sof) cap_len = 0;
        if (cap_len < PKT_MAX) cap_buf[cap_len] = tx_d;
        cap_len++;
        if (tx_eof) begin // Hand the whole packet over
          pkt     = cap_buf;
          pkt_len = cap_len;
          pkt_cnt++;
        end
      end
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] pkt_word(input int idx);
    return {pkt[idx], pkt[idx+1], pkt[idx+2], pkt[idx+3]};
  endfunction

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic set_row(input int idx, input string name, input int beh,
                         input bit exp_ok, input int exp_disc);
    row_name[idx]     = name;
    row_beh[idx]      = beh;
    row_exp_ok[idx]   = exp_ok;
    row_exp_disc[idx] = exp_disc;
  endtask

  task automatic put_word(input int idx, input logic [31:0] w);
    int i;
    for (i = 0; i < 4; i++) reply[idx + i] = w[31 - 8*i -: 8];
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    fsm_rst = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    fsm_rst = 1'b0;
  endtask

  ////////////////////////////////////////
  // Server model
  ////////////////////////////////////////

  task automatic send_reply(input msg_type_t mtype, input xid_t xid, input int len_delta);
    int i;
    for (i = 0; i < REPLY_LEN; i++) reply[i] = 8'h00;
    reply[0] = `DHCP_OP_REPLY;
    reply[1] = `DHCP_HTYPE_ETH;
    reply[2] = `DHCP_HLEN_ETH;
    put_word(4, xid);
    put_word(16, offer_ip);
    for (i = 0; i < 6; i++) reply[28 + i] = MAC[47 - 8*i -: 8];
    put_word(236, `DHCP_MAGIC_COOKIE);
    reply[240] = `DHCP_OPT_MSG_TYPE;
    reply[241] = 8'd1;
    reply[242] = mtype;
    reply[243] = `DHCP_OPT_SERVER_ID;
    reply[244] = 8'd4;
    put_word(245, SERVER_ID);
    reply[249] = `DHCP_OPT_SUBNET_MASK;
    reply[250] = 8'd4;
    put_word(251, offer_mask);
    reply[255] = `DHCP_OPT_LEASE_TIME;
    reply[256] = 8'd4;
    put_word(257, LEASE);
    reply[261] = `DHCP_OPT_PAD;
    reply[262] = 8'd12; // Host name, unknown to the parser
    reply[263] = 8'd2;
    reply[264] = 8'h61;
    reply[265] = 8'h62;
    reply[266] = `DHCP_OPT_END;
    for (i = 0; i < REPLY_LEN; i++) begin
      @(posedge clk);
      #1;
      rx_v        = 1'b1;
      rx_d        = reply[i];
      rx_sof      = (i == 0);
      rx_eof      = (i == REPLY_LEN - 1);
      rx_src_port = `DHCP_SRV_PORT;
      rx_length   = len_t'(REPLY_LEN + len_delta);
    end
    @(posedge clk);
    #1;
    rx_v   = 1'b0;
    rx_sof = 1'b0;
    rx_eof = 1'b0;
    rx_d   = 8'h00;
  endtask

  task automatic handle_packet(input int beh);
    msg_type_t mtype;
    mtype = pkt[242];
    if (pkt_len != `DHCP_TX_LEN)
      report_mismatch($sformatf("packet has %0d bytes, expected %0d", pkt_len, `DHCP_TX_LEN));
    if (pkt[0] !== 8'd1 || pkt[1] !== 8'd1 || pkt[2] !== 8'd6)
      report_mismatch("op, htype or hlen wrong");
    if ({pkt[28], pkt[29], pkt[30], pkt[31], pkt[32], pkt[33]} !== MAC)
      report_mismatch("chaddr does not hold the MAC");
    if (pkt_word(236) !== 32'h63825363)
      report_mismatch("magic cookie wrong");
    if (pkt[240] !== 8'd53 || pkt[241] !== 8'd1)
      report_mismatch("message type option missing");
    if (mtype === 8'd1) begin
      discs++;
      if (pkt[243] !== 8'd255) report_mismatch("DISCOVER options not closed by END");
      if (discs > 1 && pkt_word(4) === disc_xid) report_mismatch("retry reused the old xid");
      disc_xid = pkt_word(4);
      if (beh == SRV_WRONG_XID && discs == 1) begin
        bad_offer = 1'b1;
        send_reply(8'd2, disc_xid ^ 32'h00ff_00ff, 0);
      end else if (beh == SRV_BAD_LEN && discs == 1) begin
        bad_offer = 1'b1;
        send_reply(8'd2, disc_xid, 3);
      end else if (beh != SRV_SILENT) begin
        bad_offer = 1'b0;
        send_reply(8'd2, disc_xid, 0);
      end
    end else if (mtype === 8'd3) begin
      reqs++;
      if (bad_offer) report_mismatch("REQUEST follows an OFFER that should be dropped");
      if (pkt_word(4) !== disc_xid)
        report_mismatch($sformatf("REQUEST xid %h, DISCOVER had %h", pkt_word(4), disc_xid));
      if (pkt[243] !== 8'd50 || pkt[244] !== 8'd4 || pkt_word(245) !== offer_ip)
        report_mismatch($sformatf("requested IP option wrong, offered %h", offer_ip));
      if (pkt[249] !== 8'd54 || pkt[250] !== 8'd4 || pkt_word(251) !== SERVER_ID)
        report_mismatch("server id option wrong");
      if (pkt[255] !== 8'd255) report_mismatch("REQUEST options not closed by END");
      if (beh == SRV_NAK && reqs == 1) send_reply(8'd6, disc_xid, 0);
      else send_reply(8'd5, disc_xid, 0);
    end else begin
      report_mismatch($sformatf("unexpected message type %0d", mtype));
    end
  endtask

  task automatic run_row(input int r);
    int   waited;
    int   seen;
    logic stuck;
    discs     = 0;
    reqs      = 0;
    bad_offer = 1'b0;
    disc_xid  = '0;
    stuck     = 1'b0;
    rng        = lcg_next(rng);
    offer_ip   = {8'd10, 8'd1, rng[23:8]};
    rng        = lcg_next(rng);
    offer_mask = 32'hffff_ffff << (8 + rng[30:28]);
    apply_reset();
    if (tx_v !== 1'b0 || tx_sof !== 1'b0 || tx_eof !== 1'b0 || ok !== 1'b0 ||
        timeout !== 1'b0 || ipv4_val !== 1'b0)
      report_mismatch("outputs not low after reset");
    ipv4_req = 1'b1;
    @(posedge clk);
    #1;
    ipv4_req = 1'b0;
    seen = pkt_cnt;
    while (ok_cnt == 0 && to_cnt == 0 && !stuck) begin
      waited = 0;
      while (pkt_cnt == seen && ok_cnt == 0 && to_cnt == 0 && waited < WAIT_LIMIT) begin
        @(posedge clk);
        waited++;
      end
      if (waited >= WAIT_LIMIT) begin
        $display("Error at %0t ns: client sent nothing and gave no result", $time);
        err_cnt++;
        stuck = 1'b1;
      end else if (pkt_cnt != seen) begin
        seen = pkt_cnt;
        handle_packet(row_beh[r]);
      end
    end
    repeat (50) @(posedge clk); // Catch stray pulses or packets
    if (pkt_cnt != seen) report_mismatch("extra packet after the result");
    if (discs != row_exp_disc[r])
      report_mismatch($sformatf("%0d DISCOVERs, expected %0d", discs, row_exp_disc[r]));
    if (row_exp_ok[r]) begin
      if (ok_cnt != 1 || to_cnt != 0)
        report_mismatch($sformatf("ok pulses %0d, timeout pulses %0d", ok_cnt, to_cnt));
      if (ipv4_val !== 1'b1) report_mismatch("ipv4_val low after ACK");
      if (ipv4_addr !== offer_ip)
        report_mismatch($sformatf("ipv4_addr %h, expected %h", ipv4_addr, offer_ip));
      if (ipv4_mask !== offer_mask)
        report_mismatch($sformatf("ipv4_mask %h, expected %h", ipv4_mask, offer_mask));
    end else begin
      if (to_cnt != 1 || ok_cnt != 0)
        report_mismatch($sformatf("timeout pulses %0d, ok pulses %0d", to_cnt, ok_cnt));
      if (val_cnt != 0) report_mismatch("ipv4_val went high without a lease");
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int r;
    int err_before;
    clk         = 1'b0;
    fsm_rst     = 1'b1;
    rx_d        = 8'h00;
    rx_v        = 1'b0;
    rx_sof      = 1'b0;
    rx_eof      = 1'b0;
    rx_err      = 1'b0;
    rx_src_port = '0;
    rx_length   = '0;
    ipv4_req    = 1'b0;
    err_cnt     = 0;
    pass_cnt    = 0;
    rng         = 32'h2f2b;
    set_row(0, "good",          SRV_GOOD,      1'b1, 1);
    set_row(1, "wrong_xid",     SRV_WRONG_XID, 1'b1, 2);
    set_row(2, "nak_then_good", SRV_NAK,       1'b1, 2);
    set_row(3, "silent",        SRV_SILENT,    1'b0, RETRIES + 1);
    set_row(4, "bad_length",    SRV_BAD_LEN,   1'b1, 2);
    for (r = 0; r < NUM_ROWS; r++) begin
      err_before = err_cnt;
      run_row(r);
      if (err_cnt == err_before) pass_cnt++;
      $display("[%0t ns] scenario %0d %s: %s", $time, r, row_name[r],
               (err_cnt == err_before) ? "PASS" : "FAIL");
    end
    $display("Summary: %0d scenarios, %0d clean, %0d with errors, %0d check errors",
             NUM_ROWS, pass_cnt, NUM_ROWS - pass_cnt, err_cnt);
    if (err_cnt == 0 && pass_cnt == NUM_ROWS) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Hang guard
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired at %0t ns: the run hung", $time);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire
